/* streamer_cfg_pkg.sv */
//////////////////////////////////////////////////
// Element sizes, channel ids and FP8/FP16 element
// views, shared by every streamer block
//////////////////////////////////////////////////
package streamer_cfg_pkg;

  // Addresses count elements, not bytes
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned ELEM_W  = 16;
  localparam int unsigned NUM_SRC = 3;

  // Load channel ids, the store channel takes NUM_SRC
  localparam int unsigned X_ID = 0;
  localparam int unsigned W_ID = 1;
  localparam int unsigned Y_ID = 2;

  // Cast direction for fp_cast
  localparam bit WIDEN  = 1'b0;
  localparam bit NARROW = 1'b1;

  // One 16-bit element, read as FP16 or as E5M2 in the upper byte
  typedef union packed {
    struct packed {
      logic       sign;
      logic [4:0] exp;
      logic [9:0] man;
    } fp16;
    struct packed {
      logic       sign;
      logic [4:0] exp;
      logic [1:0] man;
      logic [7:0] pad;
    } fp8;
  } elem_u;

  typedef enum logic {
    FMT_FP16,
    FMT_FP8
  } cast_fmt_e;

endpackage

/* streamer_ctrl_pkg.sv */
//////////////////////////////////////////////////
// Control and flag structs of the channels and of
// the streamer top level
//////////////////////////////////////////////////
package streamer_ctrl_pkg;

  // One strided run, len counts elements
  typedef struct packed {
    logic [streamer_cfg_pkg::ADDR_W-1:0] base;
    logic [15:0]                         stride;
    logic [15:0]                         len;
  } chan_ctrl_t;

  // Whole streamer, sampled on start
  typedef struct packed {
    chan_ctrl_t                  x;
    chan_ctrl_t                  w;
    chan_ctrl_t                  y;
    chan_ctrl_t                  z;
    // Format held in memory for X, W and Y
    streamer_cfg_pkg::cast_fmt_e src_fmt;
    // Format written back for Z
    streamer_cfg_pkg::cast_fmt_e dst_fmt;
  } streamer_ctrl_t;

  // Done bits are one-cycle pulses
  typedef struct packed {
    logic busy;
    logic x_done;
    logic w_done;
    logic y_done;
    logic z_done;
  } streamer_flags_t;

endpackage

/* tcdm_if.sv */
//////////////////////////////////////////////////
// TCDM request/response bus, one element per beat
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface tcdm_if;

  // Request side, wen high means read
  logic                                req;
  logic                                gnt;
  logic [streamer_cfg_pkg::ADDR_W-1:0] add;
  logic                                wen;
  logic [streamer_cfg_pkg::ELEM_W-1:0] data;
  // One r_valid per granted read, in order
  logic [streamer_cfg_pkg::ELEM_W-1:0] r_data;
  logic                                r_valid;

  modport initiator (output req, add, wen, data, input gnt, r_data, r_valid);
  modport target    (input req, add, wen, data, output gnt, r_data, r_valid);

endinterface

/* elem_stream_if.sv */
//////////////////////////////////////////////////
// Valid/ready element stream between the engine
// and the streamer channels
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface elem_stream_if;

  logic                                valid;
  logic                                ready;
  logic [streamer_cfg_pkg::ELEM_W-1:0] data;
  // Marks the final element of a run
  logic                                last;

  modport source (output valid, data, last, input ready);
  modport sink   (input valid, data, last, output ready);

endinterface

/* fp_cast.sv */
//////////////////////////////////////////////////
// Combinational E5M2 <-> FP16 cast, direction by
// parameter, bypassed when en_i is low
//////////////////////////////////////////////////
`timescale 1ns/100ps

module fp_cast #(
  parameter bit CAST_DIR = streamer_cfg_pkg::WIDEN
) (
  input  streamer_cfg_pkg::elem_u src_i,
  input  logic                    en_i,
  output streamer_cfg_pkg::elem_u dst_o
);

  streamer_cfg_pkg::elem_u widened;
  streamer_cfg_pkg::elem_u narrowed;
  logic                    round_up;
  logic [6:0]              exp_man;

  // Same 5-bit exponent and bias, so widening is exact
  always_comb begin
    widened.fp16.sign = src_i.fp8.sign;
    widened.fp16.exp  = src_i.fp8.exp;
    widened.fp16.man  = {src_i.fp8.man, 8'h00};
  end

  // Guard at man[7], sticky below, ties go to even
  assign round_up = src_i.fp16.man[7] &
                    ((|src_i.fp16.man[6:0]) | src_i.fp16.man[8]);
  // Carry out of the mantissa bumps the exponent, up to Inf
  assign exp_man  = {src_i.fp16.exp, src_i.fp16.man[9:8]} + 7'(round_up);

  always_comb begin
    narrowed.fp8.sign = src_i.fp16.sign;
    narrowed.fp8.pad  = 8'h00;
    if (src_i.fp16.exp == 5'h1f) begin
      narrowed.fp8.exp = 5'h1f;
      // Inf kept, any NaN becomes quiet NaN
      narrowed.fp8.man = (src_i.fp16.man != '0) ? 2'b10 : 2'b00;
    end else begin
      {narrowed.fp8.exp, narrowed.fp8.man} = exp_man;
    end
  end

  assign dst_o = !en_i                                  ? src_i    :
                 (CAST_DIR == streamer_cfg_pkg::NARROW) ? narrowed : widened;

endmodule

/* stream_source.sv */
//////////////////////////////////////////////////
// Load channel: strided TCDM reads into a credit
// limited FIFO, widened and sent out as a stream
//////////////////////////////////////////////////
`timescale 1ns/100ps

module stream_source #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  streamer_ctrl_pkg::chan_ctrl_t ctrl_i,
  input  logic                          cast_en_i,
  tcdm_if.initiator                     tcdm,
  elem_stream_if.source                 stream,
  output logic                          done_o
);

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  streamer_cfg_pkg::elem_u             fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]                    wr_ptr;
  logic [PTR_W-1:0]                    rd_ptr;
  logic [CNT_W-1:0]                    fifo_cnt;
  logic [CNT_W-1:0]                    outst_cnt;
  logic [15:0]                         rd_left;
  logic [15:0]                         beat_cnt;
  logic [15:0]                         len_q;
  logic [15:0]                         stride_q;
  logic [streamer_cfg_pkg::ADDR_W-1:0] addr_q;
  logic                                issue;
  logic                                push;
  logic                                pop;

  assign issue = tcdm.req & tcdm.gnt;
  assign push  = tcdm.r_valid;
  assign pop   = stream.valid & stream.ready;

  // Reads in flight plus queued entries never exceed the FIFO
  assign tcdm.req  = (rd_left != '0) && ((outst_cnt + fifo_cnt) < CNT_W'(FIFO_DEPTH));
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = 1'b1;
  assign tcdm.data = '0;

  // Head of FIFO drives the stream
  assign stream.valid = (fifo_cnt != '0);
  assign stream.last  = stream.valid && (beat_cnt == len_q - 16'd1);

  fp_cast #(
    .CAST_DIR ( streamer_cfg_pkg::WIDEN )
  ) i_cast (
    .src_i ( fifo_mem[rd_ptr] ),
    .en_i  ( cast_en_i        ),
    .dst_o ( stream.data      )
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      rd_left   <= '0;
      beat_cnt  <= '0;
      outst_cnt <= '0;
      fifo_cnt  <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      done_o    <= 1'b0;
    end else begin
      if (start_i) begin
        rd_left  <= ctrl_i.len;
        beat_cnt <= '0;
      end else begin
        if (issue) rd_left <= rd_left - 16'd1;
        if (pop) beat_cnt <= beat_cnt + 16'd1;
      end
      outst_cnt <= outst_cnt + CNT_W'(issue) - CNT_W'(push);
      fifo_cnt  <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
      if (push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // pulse one cycle after the final beat
      done_o <= pop & stream.last;
    end
  end

  // Run registers and FIFO storage
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
      len_q    <= ctrl_i.len;
    end else if (issue) begin
      addr_q <= addr_q + streamer_cfg_pkg::ADDR_W'(stride_q);
    end
    if (push) fifo_mem[wr_ptr] <= tcdm.r_data;
  end

  // Credits must cover every response routed back by the arbiter
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    push |-> (fifo_cnt < CNT_W'(FIFO_DEPTH)));

endmodule

/* stream_sink.sv */
//////////////////////////////////////////////////
// Store channel: narrows each stream beat and
// writes it to base + index * stride
//////////////////////////////////////////////////
`timescale 1ns/100ps

module stream_sink (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  streamer_ctrl_pkg::chan_ctrl_t ctrl_i,
  input  logic                          cast_en_i,
  tcdm_if.initiator                     tcdm,
  elem_stream_if.sink                   stream,
  output logic                          done_o
);

  streamer_cfg_pkg::elem_u             cast_data;
  logic [streamer_cfg_pkg::ELEM_W-1:0] data_q;
  logic [streamer_cfg_pkg::ADDR_W-1:0] addr_q;
  logic [15:0]                         stride_q;
  logic [15:0]                         left;
  logic                                req_q;
  logic                                accept;
  logic                                wr_gnt;

  // Only one write held at a time
  assign stream.ready = (left != '0) && !req_q;
  assign accept       = stream.valid & stream.ready;
  assign wr_gnt       = req_q & tcdm.gnt;

  assign tcdm.req  = req_q;
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = 1'b0;
  assign tcdm.data = data_q;

  fp_cast #(
    .CAST_DIR ( streamer_cfg_pkg::NARROW )
  ) i_cast (
    .src_i ( stream.data ),
    .en_i  ( cast_en_i   ),
    .dst_o ( cast_data   )
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      left   <= '0;
      req_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      if (start_i) left <= ctrl_i.len;
      else if (wr_gnt) left <= left - 16'd1;
      if (accept) req_q <= 1'b1;
      else if (wr_gnt) req_q <= 1'b0;
      // Grant of the len-th write ends the run
      done_o <= wr_gnt && (left == 16'd1);
    end
  end

  // Address steps once per granted write
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= ctrl_i.base;
      stride_q <= ctrl_i.stride;
    end else if (wr_gnt) begin
      addr_q <= addr_q + streamer_cfg_pkg::ADDR_W'(stride_q);
    end
    if (accept) data_q <= cast_data;
  end

  // Write stays put until the arbiter grants it
  a_hold_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    (tcdm.req && !tcdm.gnt) |=> ($stable(tcdm.data) && $stable(tcdm.add)));

  // Engine's last must line up with the programmed length
  a_last_on_len: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    accept |-> (stream.last == (left == 16'd1)));

endmodule

/* tcdm_ldst_arbiter.sv */
//////////////////////////////////////////////////
// Round-robin arbiter of the load and store
// channels onto one TCDM port, routes read data
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tcdm_ldst_arbiter #(
  parameter int unsigned N_IN = 4
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      clear_i,
  tcdm_if.target    in [N_IN],
  tcdm_if.initiator out
);

  localparam int unsigned IDX_W = (N_IN > 1) ? $clog2(N_IN) : 1;

  logic [N_IN-1:0]                     req_vec;
  logic [N_IN-1:0]                     wen_vec;
  logic [streamer_cfg_pkg::ADDR_W-1:0] add_vec  [N_IN];
  logic [streamer_cfg_pkg::ELEM_W-1:0] data_vec [N_IN];
  logic [IDX_W-1:0]                    rr_ptr;
  logic [IDX_W-1:0]                    sel;
  logic                                sel_valid;
  logic                                grant;
  logic                                rd_grant;
  // Requester ids of reads still waiting for data
  logic [IDX_W-1:0]                    id_mem [2];
  logic                                id_wr;
  logic                                id_rd;
  logic [1:0]                          id_cnt;

  for (genvar i = 0; i < N_IN; i++) begin : gen_in
    assign req_vec[i]    = in[i].req;
    assign wen_vec[i]    = in[i].wen;
    assign add_vec[i]    = in[i].add;
    assign data_vec[i]   = in[i].data;
    assign in[i].gnt     = grant && (sel == IDX_W'(i));
    assign in[i].r_valid = out.r_valid && (id_mem[id_rd] == IDX_W'(i));
    assign in[i].r_data  = out.r_data;
  end

  // First requester at or after the pointer wins
  always_comb begin
    int unsigned idx;
    sel       = '0;
    sel_valid = 1'b0;
    for (int unsigned k = 0; k < N_IN; k++) begin
      idx = (rr_ptr + k) % N_IN;
      if (!sel_valid && req_vec[idx]) begin
        sel       = IDX_W'(idx);
        sel_valid = 1'b1;
      end
    end
  end

  // No new grants while clearing
  assign out.req  = sel_valid & !clear_i;
  assign out.add  = add_vec[sel];
  assign out.wen  = wen_vec[sel];
  assign out.data = data_vec[sel];
  assign grant    = out.req & out.gnt;
  assign rd_grant = grant & out.wen;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      rr_ptr <= '0;
      id_wr  <= 1'b0;
      id_rd  <= 1'b0;
      id_cnt <= '0;
    end else begin
      // Winner drops to lowest priority
      if (grant) rr_ptr <= (sel == IDX_W'(N_IN - 1)) ? '0 : sel + 1'b1;
      if (rd_grant) id_wr <= ~id_wr;
      if (out.r_valid) id_rd <= ~id_rd;
      id_cnt <= id_cnt + 2'(rd_grant) - 2'(out.r_valid);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_grant) id_mem[id_wr] <= sel;
  end

  // Memory answers only reads this arbiter granted
  a_rvalid_has_id: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    out.r_valid |-> (id_cnt != 2'd0));

endmodule

/* streamer_top.sv */
//////////////////////////////////////////////////
// Streamer top: X/W/Y loads, Z store and the
// shared TCDM port, all on plain ports
//////////////////////////////////////////////////
`timescale 1ns/100ps

module streamer_top #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter int unsigned N_IN       = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                clear_i,
  input  logic                                start_i,
  input  streamer_ctrl_pkg::streamer_ctrl_t   ctrl_i,
  output streamer_ctrl_pkg::streamer_flags_t  flags_o,
  // Memory port
  output logic                                mem_req_o,
  input  logic                                mem_gnt_i,
  output logic [streamer_cfg_pkg::ADDR_W-1:0] mem_add_o,
  output logic                                mem_wen_o,
  output logic [streamer_cfg_pkg::ELEM_W-1:0] mem_data_o,
  input  logic [streamer_cfg_pkg::ELEM_W-1:0] mem_r_data_i,
  input  logic                                mem_r_valid_i,
  // Load streams
  output logic                                x_valid_o,
  input  logic                                x_ready_i,
  output logic [streamer_cfg_pkg::ELEM_W-1:0] x_data_o,
  output logic                                x_last_o,
  output logic                                w_valid_o,
  input  logic                                w_ready_i,
  output logic [streamer_cfg_pkg::ELEM_W-1:0] w_data_o,
  output logic                                w_last_o,
  output logic                                y_valid_o,
  input  logic                                y_ready_i,
  output logic [streamer_cfg_pkg::ELEM_W-1:0] y_data_o,
  output logic                                y_last_o,
  // Store stream
  input  logic                                z_valid_i,
  output logic                                z_ready_o,
  input  logic [streamer_cfg_pkg::ELEM_W-1:0] z_data_i,
  input  logic                                z_last_i
);

  localparam int unsigned Z_ID = streamer_cfg_pkg::NUM_SRC;

  streamer_ctrl_pkg::chan_ctrl_t src_ctrl [streamer_cfg_pkg::NUM_SRC];
  logic [N_IN-1:0]               done;
  logic [N_IN-1:0]               pend_q;
  logic                          load_cast;
  logic                          store_cast;

  // Arbiter ports 0..2 are loads, 3 is the store
  tcdm_if        ch_tcdm [N_IN] ();
  tcdm_if        mem_tcdm ();
  elem_stream_if src_stream [streamer_cfg_pkg::NUM_SRC] ();
  elem_stream_if z_stream ();

  assign load_cast  = (ctrl_i.src_fmt == streamer_cfg_pkg::FMT_FP8);
  assign store_cast = (ctrl_i.dst_fmt == streamer_cfg_pkg::FMT_FP8);

  assign src_ctrl[streamer_cfg_pkg::X_ID] = ctrl_i.x;
  assign src_ctrl[streamer_cfg_pkg::W_ID] = ctrl_i.w;
  assign src_ctrl[streamer_cfg_pkg::Y_ID] = ctrl_i.y;

  for (genvar i = 0; i < streamer_cfg_pkg::NUM_SRC; i++) begin : gen_src
    stream_source #(
      .FIFO_DEPTH ( FIFO_DEPTH )
    ) i_source (
      .clk_i     ( clk_i         ),
      .rst_n_i   ( rst_n_i       ),
      .clear_i   ( clear_i       ),
      .start_i   ( start_i       ),
      .ctrl_i    ( src_ctrl[i]   ),
      .cast_en_i ( load_cast     ),
      .tcdm      ( ch_tcdm[i]    ),
      .stream    ( src_stream[i] ),
      .done_o    ( done[i]       )
    );
  end

  stream_sink i_sink (
    .clk_i     ( clk_i         ),
    .rst_n_i   ( rst_n_i       ),
    .clear_i   ( clear_i       ),
    .start_i   ( start_i       ),
    .ctrl_i    ( ctrl_i.z      ),
    .cast_en_i ( store_cast    ),
    .tcdm      ( ch_tcdm[Z_ID] ),
    .stream    ( z_stream      ),
    .done_o    ( done[Z_ID]    )
  );

  tcdm_ldst_arbiter #(
    .N_IN ( N_IN )
  ) i_arbiter (
    .clk_i   ( clk_i    ),
    .rst_n_i ( rst_n_i  ),
    .clear_i ( clear_i  ),
    .in      ( ch_tcdm  ),
    .out     ( mem_tcdm )
  );

  // Flatten the memory side
  assign mem_req_o        = mem_tcdm.req;
  assign mem_add_o        = mem_tcdm.add;
  assign mem_wen_o        = mem_tcdm.wen;
  assign mem_data_o       = mem_tcdm.data;
  assign mem_tcdm.gnt     = mem_gnt_i;
  assign mem_tcdm.r_data  = mem_r_data_i;
  assign mem_tcdm.r_valid = mem_r_valid_i;

  // Flatten the streams
  assign x_valid_o = src_stream[streamer_cfg_pkg::X_ID].valid;
  assign x_data_o  = src_stream[streamer_cfg_pkg::X_ID].data;
  assign x_last_o  = src_stream[streamer_cfg_pkg::X_ID].last;
  assign src_stream[streamer_cfg_pkg::X_ID].ready = x_ready_i;
  assign w_valid_o = src_stream[streamer_cfg_pkg::W_ID].valid;
  assign w_data_o  = src_stream[streamer_cfg_pkg::W_ID].data;
  assign w_last_o  = src_stream[streamer_cfg_pkg::W_ID].last;
  assign src_stream[streamer_cfg_pkg::W_ID].ready = w_ready_i;
  assign y_valid_o = src_stream[streamer_cfg_pkg::Y_ID].valid;
  assign y_data_o  = src_stream[streamer_cfg_pkg::Y_ID].data;
  assign y_last_o  = src_stream[streamer_cfg_pkg::Y_ID].last;
  assign src_stream[streamer_cfg_pkg::Y_ID].ready = y_ready_i;
  assign z_stream.valid = z_valid_i;
  assign z_stream.data  = z_data_i;
  assign z_stream.last  = z_last_i;
  assign z_ready_o      = z_stream.ready;

  // Channels with len 0 count as done at start
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      pend_q <= '0;
    end else if (start_i) begin
      pend_q <= {ctrl_i.z.len != '0, ctrl_i.y.len != '0,
                 ctrl_i.w.len != '0, ctrl_i.x.len != '0};
    end else begin
      pend_q <= pend_q & ~done;
    end
  end

  assign flags_o.busy   = |pend_q;
  assign flags_o.x_done = done[streamer_cfg_pkg::X_ID];
  assign flags_o.w_done = done[streamer_cfg_pkg::W_ID];
  assign flags_o.y_done = done[streamer_cfg_pkg::Y_ID];
  assign flags_o.z_done = done[Z_ID];

endmodule

/* tb_checker.sv */
//////////////////////////////////////////////////
// Streamer scoreboard: predicts load beats and
// store writes, counts mismatches
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_checker (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               clear_i,
  input  logic                               start_i,
  input  streamer_ctrl_pkg::streamer_ctrl_t  ctrl_i,
  input  streamer_ctrl_pkg::streamer_flags_t flags_i,
  input  logic [2:0]                         ld_valid_i,
  input  logic [2:0]                         ld_ready_i,
  input  logic [2:0]                         ld_last_i,
  input  logic [47:0]                        ld_data_i,
  input  logic                               z_valid_i,
  input  logic                               z_ready_i,
  input  logic [15:0]                        z_data_i,
  input  logic                               mem_req_i,
  input  logic                               mem_gnt_i,
  input  logic [31:0]                        mem_add_i,
  input  logic                               mem_wen_i,
  input  logic [15:0]                        mem_data_i,
  output int                                 errors_o
);

  streamer_ctrl_pkg::chan_ctrl_t cc [3];
  logic [15:0]                   ld_cnt [3];
  logic [3:0]                    done_seen;
  logic [15:0]                   z_acc;
  logic [15:0]                   z_wr;
  logic [15:0]                   exp_data_q [$];
  logic [31:0]                   exp_add_q [$];

  assign cc[0] = ctrl_i.x;
  assign cc[1] = ctrl_i.w;
  assign cc[2] = ctrl_i.y;

  // Round to E5M2 by integer rounding of the upper byte
  function automatic logic [15:0] round_to_e5m2(input logic [15:0] v);
    logic [8:0] up;
    if (v[14:10] == 5'h1f) begin
      return (v[9:0] != 0) ? {v[15], 5'h1f, 2'b10, 8'h00} : {v[15], 5'h1f, 10'h000};
    end
    up = {1'b0, v[15:8]};
    if (v[7:0] > 8'h80 || (v[7:0] == 8'h80 && v[8])) begin
      up = up + 9'd1;
    end
    return {up[7:0], 8'h00};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %h actual %h", tb_streamer.test_name, what, exp, act);
      errors_o++;
    end
  endtask

  initial errors_o = 0;

  always @(posedge clk_i) begin
    logic [31:0] a;
    logic [15:0] w;
    if (!rst_n_i || clear_i || start_i) begin
      for (int c = 0; c < 3; c++) ld_cnt[c] <= '0;
      done_seen <= '0;
      z_acc     <= '0;
      z_wr      <= '0;
      exp_data_q.delete();
      exp_add_q.delete();
    end else begin
      for (int c = 0; c < 3; c++) begin
        if (ld_valid_i[c] && ld_ready_i[c]) begin
          a = cc[c].base + 32'(ld_cnt[c]) * 32'(cc[c].stride);
          w = tb_streamer.mem[a[9:0]];
          // E5M2 sits in the upper byte, widen pads zeros
          if (ctrl_i.src_fmt == streamer_cfg_pkg::FMT_FP8) w = {w[15:8], 8'h00};
          if (ld_cnt[c] >= cc[c].len) begin
            $display("Load channel %0d sent a beat beyond its length", c);
            errors_o++;
          end
          compare_value($sformatf("ch%0d data beat %0d", c, ld_cnt[c]), 32'(w),
                        32'(ld_data_i[16*c +: 16]));
          compare_value($sformatf("ch%0d last beat %0d", c, ld_cnt[c]),
                        32'(ld_cnt[c] == cc[c].len - 16'd1), 32'(ld_last_i[c]));
          ld_cnt[c] <= ld_cnt[c] + 16'd1;
        end
      end
      // Each accepted Z beat predicts one write
      if (z_valid_i && z_ready_i) begin
        exp_data_q.push_back((ctrl_i.dst_fmt == streamer_cfg_pkg::FMT_FP8) ?
                             round_to_e5m2(z_data_i) : z_data_i);
        exp_add_q.push_back(ctrl_i.z.base + 32'(z_acc) * 32'(ctrl_i.z.stride));
        z_acc <= z_acc + 16'd1;
      end
      if (mem_req_i && mem_gnt_i && !mem_wen_i) begin
        if (exp_data_q.size() == 0) begin
          $display("Memory write seen with no accepted Z beat behind it");
          errors_o++;
        end else begin
          compare_value($sformatf("z addr %0d", z_wr), exp_add_q.pop_front(), mem_add_i);
          compare_value($sformatf("z data %0d", z_wr), 32'(exp_data_q.pop_front()),
                        32'(mem_data_i));
        end
        z_wr <= z_wr + 16'd1;
      end
      check_done(0, flags_i.x_done, ld_cnt[0], cc[0].len);
      check_done(1, flags_i.w_done, ld_cnt[1], cc[1].len);
      check_done(2, flags_i.y_done, ld_cnt[2], cc[2].len);
      check_done(3, flags_i.z_done, z_wr, ctrl_i.z.len);
    end
  end

  // Done must come once, after the whole run
  task automatic check_done(input int c, input logic d, input logic [15:0] n,
                            input logic [15:0] len);
    if (d) begin
      if (done_seen[c]) begin
        $display("Channel %0d pulsed done twice in one run", c);
        errors_o++;
      end
      done_seen[c] <= 1'b1;
      compare_value($sformatf("ch%0d count at done", c), 32'(len), 32'(n));
    end
  endtask

endmodule

/* tb_streamer.sv */
//////////////////////////////////////////////////
// Streamer testbench with memory model, table
// driven runs, random grants and back-pressure
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_streamer;

  localparam int N_TESTS = 7;
  localparam int TIMEOUT = 3000;

  logic clk_i, rst_n_i, clear_i, start_i;
  streamer_ctrl_pkg::streamer_ctrl_t  ctrl;
  streamer_ctrl_pkg::streamer_flags_t flags;
  logic        mem_req, mem_gnt, mem_wen, mem_r_valid;
  logic [31:0] mem_add;
  logic [15:0] mem_data, mem_r_data;
  logic [2:0]  ld_valid, ld_ready, ld_last;
  logic [47:0] ld_data;
  logic        z_valid, z_ready, z_last, z_run, bp;
  logic [15:0] z_data, z_len;
  int          z_idx;
  logic [15:0] mem [1024];
  logic [15:0] rnd;
  string       test_name;
  int          tb_errors, chk_errors;

  // Test table
  string                             t_name [N_TESTS];
  streamer_ctrl_pkg::streamer_ctrl_t t_ctrl [N_TESTS];
  logic                              t_bp [N_TESTS];
  logic                              t_clear [N_TESTS];

  // Ties to even and odd, carry into the exponent, overflow, NaN and -Inf
  logic [15:0] special [6] = '{16'h3c80, 16'h3d80, 16'h3bff, 16'h7bff, 16'h7e01, 16'hfc00};

  streamer_top #(.FIFO_DEPTH(4), .N_IN(4)) dut0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .clear_i(clear_i), .start_i(start_i),
    .ctrl_i(ctrl), .flags_o(flags),
    .mem_req_o(mem_req), .mem_gnt_i(mem_gnt), .mem_add_o(mem_add), .mem_wen_o(mem_wen),
    .mem_data_o(mem_data), .mem_r_data_i(mem_r_data), .mem_r_valid_i(mem_r_valid),
    .x_valid_o(ld_valid[0]), .x_ready_i(ld_ready[0]), .x_data_o(ld_data[15:0]),
    .x_last_o(ld_last[0]),
    .w_valid_o(ld_valid[1]), .w_ready_i(ld_ready[1]), .w_data_o(ld_data[31:16]),
    .w_last_o(ld_last[1]),
    .y_valid_o(ld_valid[2]), .y_ready_i(ld_ready[2]), .y_data_o(ld_data[47:32]),
    .y_last_o(ld_last[2]),
    .z_valid_i(z_valid), .z_ready_o(z_ready), .z_data_i(z_data), .z_last_i(z_last)
  );

  tb_checker chk0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .clear_i(clear_i), .start_i(start_i),
    .ctrl_i(ctrl), .flags_i(flags), .ld_valid_i(ld_valid), .ld_ready_i(ld_ready),
    .ld_last_i(ld_last), .ld_data_i(ld_data), .z_valid_i(z_valid), .z_ready_i(z_ready),
    .z_data_i(z_data), .mem_req_i(mem_req), .mem_gnt_i(mem_gnt), .mem_add_i(mem_add),
    .mem_wen_i(mem_wen), .mem_data_i(mem_data), .errors_o(chk_errors)
  );

  // Galois LFSR with taps at 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic draw_bit();
    draw_bit = rnd[0];
    rnd      = lfsr_next(rnd);
  endfunction

  function automatic streamer_ctrl_pkg::chan_ctrl_t chan(input int b, input int s, input int l);
    return {32'(b), 16'(s), 16'(l)};
  endfunction

  task automatic add_test(input int i, input string n, input streamer_ctrl_pkg::chan_ctrl_t x,
                          input streamer_ctrl_pkg::chan_ctrl_t w,
                          input streamer_ctrl_pkg::chan_ctrl_t y,
                          input streamer_ctrl_pkg::chan_ctrl_t z,
                          input streamer_cfg_pkg::cast_fmt_e sf,
                          input streamer_cfg_pkg::cast_fmt_e df, input logic b, input logic c);
    t_name[i]  = n;
    t_ctrl[i]  = {x, w, y, z, sf, df};
    t_bp[i]    = b;
    t_clear[i] = c;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // One granted read answers in the next cycle
  always @(posedge clk_i) begin
    mem_r_valid <= 1'b0;
    if (mem_req && mem_gnt) begin
      if (mem_wen) begin
        mem_r_valid <= 1'b1;
        mem_r_data  <= mem[mem_add[9:0]];
      end else begin
        mem[mem_add[9:0]] <= mem_data;
      end
    end
    mem_gnt  <= bp ? draw_bit() : 1'b1;
    ld_ready <= bp ? {draw_bit(), draw_bit(), draw_bit()} : 3'b111;
  end

  // Z producer sends the specials first and stored words after them
  always @(posedge clk_i) begin
    int k;
    if (!z_run) begin
      z_valid <= 1'b0;
      z_idx   <= 0;
    end else begin
      k = z_idx;
      if (z_valid && z_ready) k++;
      z_idx   <= k;
      z_valid <= (k < int'(z_len));
      z_data  <= (k < 6) ? special[k] : mem[300 + k];
      z_last  <= (k == int'(z_len) - 1);
    end
  end

  task automatic wait_idle(input string what);
    int n;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk_i);
      if (!flags.busy) break;
    end
    if (n == TIMEOUT) begin
      $display("Timed out waiting for %s in test %s", what, test_name);
      tb_errors++;
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    z_run   <= 1'b0;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    if (ld_valid != 0 || mem_req || z_ready || flags != 0) begin
      $display("Outputs not idle after clear in test %s", test_name);
      tb_errors++;
    end
  endtask

  initial begin
    logic [15:0] s;
    logic [15:0] v;
    s = 16'd27;
    for (int a = 0; a < 1024; a++) begin
      for (int b = 0; b < 16; b++) begin
        v = {v[14:0], s[0]};
        s = lfsr_next(s);
      end
      mem[a] = v;
    end
    rnd         = 16'd27;
    rst_n_i     = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    ctrl        = '0;
    bp          = 1'b0;
    mem_gnt     = 1'b0;
    mem_r_valid = 1'b0;
    mem_r_data  = '0;
    ld_ready    = '0;
    z_run       = 1'b0;
    z_len       = '0;
    z_valid     = 1'b0;
    z_data      = '0;
    z_last      = 1'b0;
    tb_errors   = 0;
    test_name   = "reset";
    add_test(0, "unit_fp16", chan(0, 1, 8), chan(100, 1, 8), chan(200, 1, 8), chan(600, 1, 6),
             streamer_cfg_pkg::FMT_FP16, streamer_cfg_pkg::FMT_FP16, 1'b0, 1'b0);
    add_test(1, "strided_mixed", chan(10, 3, 12), chan(300, 5, 7), chan(50, 2, 20),
             chan(640, 3, 9), streamer_cfg_pkg::FMT_FP16, streamer_cfg_pkg::FMT_FP16,
             1'b0, 1'b0);
    add_test(2, "fp8_widen", chan(0, 1, 10), chan(40, 2, 9), chan(400, 1, 5), chan(0, 0, 0),
             streamer_cfg_pkg::FMT_FP8, streamer_cfg_pkg::FMT_FP16, 1'b0, 1'b0);
    add_test(3, "z_narrow", chan(0, 0, 0), chan(0, 0, 0), chan(0, 0, 0), chan(700, 2, 12),
             streamer_cfg_pkg::FMT_FP16, streamer_cfg_pkg::FMT_FP8, 1'b0, 1'b0);
    add_test(4, "backpressure", chan(5, 2, 25), chan(120, 1, 30), chan(250, 4, 18),
             chan(800, 1, 20), streamer_cfg_pkg::FMT_FP8, streamer_cfg_pkg::FMT_FP8,
             1'b1, 1'b0);
    add_test(5, "clear_mid", chan(0, 1, 40), chan(100, 1, 40), chan(200, 1, 40),
             chan(900, 1, 40), streamer_cfg_pkg::FMT_FP16, streamer_cfg_pkg::FMT_FP16,
             1'b1, 1'b1);
    add_test(6, "after_clear", chan(3, 1, 8), chan(150, 2, 8), chan(220, 1, 8),
             chan(960, 1, 8), streamer_cfg_pkg::FMT_FP16, streamer_cfg_pkg::FMT_FP8,
             1'b0, 1'b0);
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int t = 0; t < N_TESTS; t++) begin
      @(posedge clk_i);
      test_name = t_name[t];
      ctrl    <= t_ctrl[t];
      bp      <= t_bp[t];
      z_len   <= t_ctrl[t].z.len;
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      z_run   <= 1'b1;
      if (t_clear[t]) begin
        repeat (15) @(posedge clk_i);
        pulse_clear();
      end else begin
        wait_idle("all channels done");
        if (flags.busy) pulse_clear();
        @(posedge clk_i);
        z_run <= 1'b0;
      end
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
streamer_cfg_pkg.sv
streamer_ctrl_pkg.sv
tcdm_if.sv
elem_stream_if.sv
fp_cast.sv
stream_source.sv
stream_sink.sv
tcdm_ldst_arbiter.sv
streamer_top.sv
tb_checker.sv
tb_streamer.sv

/* Bender.yml */
package:
  name: streamer

sources:
  - streamer_cfg_pkg.sv
  - streamer_ctrl_pkg.sv
  - tcdm_if.sv
  - elem_stream_if.sv
  - fp_cast.sv
  - stream_source.sv
  - stream_sink.sv
  - tcdm_ldst_arbiter.sv
  - streamer_top.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_streamer.sv
